// ==== Makefile ====
# Verilator build and run of the lab4 testbench
VERILATOR ?= verilator
TOP       ?= tb_lab4
FILELIST  ?= lab4.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** PASSED ***

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== lab4.f ====
src/wire_pkg.sv
src/serial_frame_timer.sv
src/adc_spi_reader.sv
src/dac_spi_writer.sv
src/quadrature_gain.sv
src/sample_shaper.sv
src/hex_display.sv
src/wirewithfeatures.sv
src/lab4.sv
verif/tb_lab4.sv

// ==== src/adc_spi_reader.sv ====
/*
 * Serial ADC front end: drives chip select and the command bits,
 * then shifts in the 12-bit conversion result MSB first.
 */
`timescale 1ns/1ps

module adc_spi_reader (
  input  logic                 clk,
  input  logic                 reset,
  input  wire_pkg::frame_pos_t pos,
  input  logic                 sdi_adc,
  output logic                 cs_adc,
  output logic                 sdo_adc,
  output logic                 sample_valid,
  output wire_pkg::sample_t    sample
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_CMD,
    S_NULL,
    S_DATA
  } state_t;

  state_t            state;
  wire_pkg::sample_t shreg;  // Assembles the result

  // ==================================================
  // Chip select, command bits, phase tracking
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= S_IDLE;
      cs_adc  <= 1'b1;
      sdo_adc <= 1'b0;
    end else if (pos.frame_start) begin
      state   <= S_CMD;
      cs_adc  <= 1'b0;
      sdo_adc <= wire_pkg::ADC_CMD[3];  // Start bit
    end else if (pos.sclk_fall) begin
      case (state)
        S_CMD: begin
          if (pos.bit_idx == wire_pkg::ADC_NULL_BIT) begin
            state   <= S_NULL;
            sdo_adc <= 1'b0;
          end else begin
            sdo_adc <= wire_pkg::ADC_CMD[2'd3 - pos.bit_idx[1:0]];
          end
        end
        S_NULL: begin
          if (pos.bit_idx == wire_pkg::ADC_DATA_FIRST) state <= S_DATA;
        end
        S_DATA: begin
          if (pos.bit_idx == wire_pkg::ADC_DATA_LAST + 1'b1) begin
            state  <= S_IDLE;
            cs_adc <= 1'b1;  // Release until next frame
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // ==================================================
  // Data capture
  // ==================================================
  always_ff @(posedge clk) begin
    if (state == S_DATA && pos.sclk_rise) begin
      shreg <= {shreg[10:0], sdi_adc};  // MSB first
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= state == S_DATA && pos.sclk_rise &&
                      pos.bit_idx == wire_pkg::ADC_DATA_LAST;
    end
  end

  assign sample = shreg;

  // Result only reported inside an active conversion
  a_valid_in_frame: assert property (@(posedge clk) disable iff (reset)
    sample_valid |-> !cs_adc);

endmodule

// ==== src/dac_spi_writer.sv ====
/*
 * Serial DAC back end: loads config nibble plus code at frame start
 * and shifts the 16-bit word out on sclk falling edges.
 */
`timescale 1ns/1ps

module dac_spi_writer (
  input  logic                 clk,
  input  logic                 reset,
  input  wire_pkg::frame_pos_t pos,
  input  wire_pkg::sample_t    code,
  output logic                 cs_dac,
  output logic                 sdo_dac
);

  logic [14:0] shreg;  // Bits still to send with the next one on top

  // Word payload loaded at frame start
  always_ff @(posedge clk) begin
    if (pos.frame_start) begin
      shreg <= {wire_pkg::DAC_CFG[2:0], code};
    end else if (pos.sclk_fall) begin
      shreg <= {shreg[13:0], 1'b0};
    end
  end

  // ==================================================
  // Pin drivers
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      cs_dac  <= 1'b1;
      sdo_dac <= 1'b0;
    end else if (pos.frame_start) begin
      cs_dac  <= 1'b0;
      sdo_dac <= wire_pkg::DAC_CFG[3];  // Period 0 bit
    end else if (pos.sclk_fall) begin
      if (pos.bit_idx == wire_pkg::DAC_BITS) begin
        cs_dac  <= 1'b1;  // Rising select latches the word
        sdo_dac <= 1'b0;
      end else if (pos.bit_idx < wire_pkg::DAC_BITS) begin
        sdo_dac <= shreg[14];
      end
    end
  end

endmodule

// ==== src/hex_display.sv ====
/*
 * Seven segment decode: DAC code on digits 0 to 2, gain on digit 3.
 * Active low, segment order gfedcba.
 */
`timescale 1ns/1ps

module hex_display (
  input  wire_pkg::sample_t code,
  input  wire_pkg::gain_t   gain,
  output logic [6:0]        hex0,
  output logic [6:0]        hex1,
  output logic [6:0]        hex2,
  output logic [6:0]        hex3
);

  function automatic logic [6:0] seg7(input logic [3:0] nib);
    case (nib)
      4'h0: seg7 = 7'b1000000;
      4'h1: seg7 = 7'b1111001;
      4'h2: seg7 = 7'b0100100;
      4'h3: seg7 = 7'b0110000;
      4'h4: seg7 = 7'b0011001;
      4'h5: seg7 = 7'b0010010;
      4'h6: seg7 = 7'b0000010;
      4'h7: seg7 = 7'b1111000;
      4'h8: seg7 = 7'b0000000;
      4'h9: seg7 = 7'b0010000;
      4'ha: seg7 = 7'b0001000;
      4'hb: seg7 = 7'b0000011;  // Lower case b
      4'hc: seg7 = 7'b1000110;
      4'hd: seg7 = 7'b0100001;  // Lower case d
      4'he: seg7 = 7'b0000110;
      default: seg7 = 7'b0001110;  // F
    endcase
  endfunction

  assign hex0 = seg7(code[3:0]);  // Least significant nibble
  assign hex1 = seg7(code[7:4]);
  assign hex2 = seg7(code[11:8]);
  assign hex3 = seg7(gain);

endmodule

// ==== src/lab4.sv ====
/*
 * Board top: maps switches, button, GPIO header 0, LEDs and
 * seven segment digits onto the signal path core.
 */
`timescale 1ns/1ps

module lab4 #(
  parameter int SCLK_DIV = 4  // 50 MHz / 8 gives 6.25 MHz sclk
) (
  input  logic        clock_50,
  input  logic        clock_50_2,   // Not used
  input  logic [2:0]  button,
  input  logic [9:0]  sw,
  output logic [6:0]  hex0_d,
  output logic        hex0_dp,
  output logic [6:0]  hex1_d,
  output logic        hex1_dp,
  output logic [6:0]  hex2_d,
  output logic        hex2_dp,
  output logic [6:0]  hex3_d,
  output logic        hex3_dp,
  output logic [9:0]  ledg,
  input  logic [1:0]  gpio0_clkin,  // Not used
  output logic [1:0]  gpio0_clkout,
  inout  wire  [31:0] gpio0_d,
  input  logic [1:0]  gpio1_clkin,  // Not used
  output logic [1:0]  gpio1_clkout,
  inout  wire  [31:0] gpio1_d
);

  logic sclk;
  logic cs_adc, sdo_adc;
  logic cs_dac, sdo_dac;
  logic resetbutton;

  // ==================================================
  // Pin mapping
  // ==================================================
  assign resetbutton = ~button[0];  // Button reads low when pressed

  // Unused header pins floating
  assign gpio0_d[31:15] = 'z;
  assign gpio0_d[10:9]  = 'z;
  assign gpio0_d[3:0]   = 'z;
  assign gpio1_d        = 'z;
  assign gpio0_clkout   = '0;
  assign gpio1_clkout   = '0;

  assign gpio0_d[14] = cs_adc;
  assign gpio0_d[13] = sdo_adc;  // Command to ADC
  assign gpio0_d[11] = sclk;
  assign gpio0_d[8]  = cs_dac;
  assign gpio0_d[7]  = sdo_dac;
  assign gpio0_d[6]  = sclk;     // Same clock on both converters

  assign ledg = {7'b0, sw[1], sw[0], resetbutton};

  // Decimal points dark
  assign hex0_dp = 1'b1;
  assign hex1_dp = 1'b1;
  assign hex2_dp = 1'b1;
  assign hex3_dp = 1'b1;

  wirewithfeatures #(.SCLK_DIV(SCLK_DIV)) i_core (
    .clk(clock_50), .reset(resetbutton), .en(sw[1]), .mode(sw[0]),
    .enc_a(gpio0_d[5]), .enc_b(gpio0_d[4]), .sdi_adc(gpio0_d[12]),
    .sclk(sclk), .cs_adc(cs_adc), .sdo_adc(sdo_adc),
    .cs_dac(cs_dac), .sdo_dac(sdo_dac),
    .hex0(hex0_d), .hex1(hex1_d), .hex2(hex2_d), .hex3(hex3_d));

endmodule

// ==== src/quadrature_gain.sv ====
/*
 * Quadrature knob decoder: synchronizes A/B and steps a
 * saturating gain on each rising edge of A.
 */
`timescale 1ns/1ps

module quadrature_gain (
  input  logic            clk,
  input  logic            reset,
  input  logic            enc_a,
  input  logic            enc_b,
  output wire_pkg::gain_t gain
);

  localparam wire_pkg::gain_t GAIN_MAX = '1;

  logic [1:0] a_sync;  // Two-flop synchronizers
  logic [1:0] b_sync;
  logic       a_q;     // Previous synced A
  logic       a_rise;

  // Synchronizer chains and A history
  always_ff @(posedge clk) begin
    a_sync <= {a_sync[0], enc_a};
    b_sync <= {b_sync[0], enc_b};
    a_q    <= a_sync[1];
  end

  assign a_rise = a_sync[1] & ~a_q;

  // ==================================================
  // Gain counter
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      gain <= wire_pkg::GAIN_RESET;
    end else if (a_rise) begin
      if (!b_sync[1]) begin
        if (gain != GAIN_MAX) gain <= gain + 1'b1;  // Clockwise
      end else begin
        if (gain != '0) gain <= gain - 1'b1;        // Counter clockwise
      end
    end
  end

endmodule

// ==== src/sample_shaper.sv ====
/*
 * Per sample processing: mute, passthrough, or gain around
 * midscale with saturation to the 12-bit DAC range.
 */
`timescale 1ns/1ps

module sample_shaper (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 sample_valid,
  input  wire_pkg::sample_t    sample,
  input  wire_pkg::shape_ctl_t ctl,
  output wire_pkg::sample_t    dac_code
);

  logic signed [12:0] centered;  // Sample minus midscale
  logic signed [17:0] scaled;    // Times gain, over 4
  logic signed [17:0] biased;
  wire_pkg::sample_t  clamped;

  // ==================================================
  // Gain path
  // ==================================================
  assign centered = $signed({1'b0, sample}) - $signed({1'b0, wire_pkg::MIDSCALE});
  assign scaled   = (centered * $signed({1'b0, ctl.gain})) >>> 2;  // Floor divide
  assign biased   = scaled + $signed({6'b0, wire_pkg::MIDSCALE});

  always_comb begin
    if (biased < 0) begin
      clamped = '0;              // Bottom rail
    end else if (biased > 18'sd4095) begin
      clamped = '1;              // Top rail
    end else begin
      clamped = biased[11:0];
    end
  end

  // Output register, updated once per frame
  always_ff @(posedge clk) begin
    if (reset) begin
      dac_code <= wire_pkg::MIDSCALE;
    end else if (sample_valid) begin
      if (!ctl.en) begin
        dac_code <= wire_pkg::MIDSCALE;  // Muted
      end else if (!ctl.mode) begin
        dac_code <= sample;
      end else begin
        dac_code <= clamped;
      end
    end
  end

endmodule

// ==== src/serial_frame_timer.sv ====
/*
 * Serial clock divider and frame sequencer shared by ADC and DAC.
 * Emits sclk edge strobes, frame start and the current bit position.
 */
`timescale 1ns/1ps

module serial_frame_timer #(
  parameter int SCLK_DIV = 4  // clk cycles per sclk half period, 2 or more
) (
  input  logic                 clk,
  input  logic                 reset,
  output logic                 sclk,
  output wire_pkg::frame_pos_t pos
);

  localparam int CNT_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;
  localparam logic [CNT_W-1:0] DIV_LAST = CNT_W'(SCLK_DIV - 1);

  logic [CNT_W-1:0] div_cnt;  // Half period counter

  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt         <= '0;
      sclk            <= 1'b0;
      pos.frame_start <= 1'b1;  // First frame starts right after reset
      pos.sclk_rise   <= 1'b0;
      pos.sclk_fall   <= 1'b0;
      pos.bit_idx     <= '0;
    end else begin
      pos.frame_start <= 1'b0;
      pos.sclk_rise   <= 1'b0;
      pos.sclk_fall   <= 1'b0;
      if (div_cnt == DIV_LAST) begin
        div_cnt <= '0;
        sclk    <= ~sclk;
        if (!sclk) begin
          pos.sclk_rise <= 1'b1;  // Middle of the bit period
        end else begin
          pos.sclk_fall <= 1'b1;  // End of period, advance position
          if (pos.bit_idx == wire_pkg::FRAME_BITS - 1'b1) begin
            pos.bit_idx     <= '0;
            pos.frame_start <= 1'b1;
          end else begin
            pos.bit_idx <= pos.bit_idx + 1'b1;
          end
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // Position stays inside the frame
  a_bit_idx_range: assert property (@(posedge clk) disable iff (reset)
    pos.bit_idx < wire_pkg::FRAME_BITS);

endmodule

// ==== src/wire_pkg.sv ====
/*
 * Shared types and constants for the ADC to DAC signal path:
 * sample and gain widths, serial frame layout, device command words
 * and the packed structs passed between the core blocks
 */
package wire_pkg;

  // ==================================================
  // Widths
  // ==================================================
  typedef logic [11:0] sample_t;   // Offset binary, midscale 2048
  typedef logic [3:0]  gain_t;     // Quarters, 4 = unity
  typedef logic [4:0]  bit_idx_t;  // Position inside a frame

  // ==================================================
  // Frame layout
  // ==================================================
  localparam bit_idx_t FRAME_BITS     = 5'd18;  // sclk periods per frame
  localparam bit_idx_t ADC_NULL_BIT   = 5'd4;   // After the 4 command bits
  localparam bit_idx_t ADC_DATA_FIRST = 5'd5;
  localparam bit_idx_t ADC_DATA_LAST  = 5'd16;  // 12 data bits, MSB first
  localparam bit_idx_t DAC_BITS       = 5'd16;  // Config nibble + code

  localparam sample_t MIDSCALE   = 12'd2048;
  localparam gain_t   GAIN_RESET = 4'd4;

  // Start, single ended, channel 0, MSB first
  localparam logic [3:0] ADC_CMD = 4'b1101;
  // Channel A, unbuffered, 1x, active
  localparam logic [3:0] DAC_CFG = 4'b0011;

  // Timer broadcast, strobes are one clk wide
  typedef struct packed {
    logic     frame_start;
    logic     sclk_rise;
    logic     sclk_fall;
    bit_idx_t bit_idx;
  } frame_pos_t;

  // Shaper controls from switches and encoder
  typedef struct packed {
    logic  en;
    logic  mode;
    gain_t gain;
  } shape_ctl_t;

endpackage

// ==== src/wirewithfeatures.sv ====
/*
 * Signal path core: frame timer, ADC reader, shaper, DAC writer,
 * encoder gain and display decode.
 */
`timescale 1ns/1ps

module wirewithfeatures #(
  parameter int SCLK_DIV = 4
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       en,
  input  logic       mode,
  input  logic       enc_a,
  input  logic       enc_b,
  input  logic       sdi_adc,
  output logic       sclk,
  output logic       cs_adc,
  output logic       sdo_adc,
  output logic       cs_dac,
  output logic       sdo_dac,
  output logic [6:0] hex0,
  output logic [6:0] hex1,
  output logic [6:0] hex2,
  output logic [6:0] hex3
);

  wire_pkg::frame_pos_t pos;           // Shared by both serial ports
  wire_pkg::sample_t    sample;
  logic                 sample_valid;
  wire_pkg::gain_t      gain;
  wire_pkg::shape_ctl_t ctl;
  wire_pkg::sample_t    dac_code;

  assign ctl = '{en: en, mode: mode, gain: gain};

  // ==================================================
  // Serial timing and converters
  // ==================================================
  serial_frame_timer #(.SCLK_DIV(SCLK_DIV)) i_timer (
    .clk(clk), .reset(reset), .sclk(sclk), .pos(pos));

  adc_spi_reader i_adc (
    .clk(clk), .reset(reset), .pos(pos), .sdi_adc(sdi_adc), .cs_adc(cs_adc),
    .sdo_adc(sdo_adc), .sample_valid(sample_valid), .sample(sample));

  sample_shaper i_shaper (
    .clk(clk), .reset(reset), .sample_valid(sample_valid), .sample(sample),
    .ctl(ctl), .dac_code(dac_code));

  dac_spi_writer i_dac (  // Picks up dac_code at next frame start
    .clk(clk), .reset(reset), .pos(pos), .code(dac_code),
    .cs_dac(cs_dac), .sdo_dac(sdo_dac));

  // User side
  quadrature_gain i_gain (
    .clk(clk), .reset(reset), .enc_a(enc_a), .enc_b(enc_b), .gain(gain));

  hex_display i_hex (
    .code(dac_code), .gain(gain), .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3));

endmodule

// ==== verif/tb_lab4.sv ====
/*
 * Testbench for the board top: serial ADC model, DAC word capture,
 * encoder driver, stimulus table with expected codes, checks
 * and a watchdog.
 */
`timescale 1ns/1ps

module tb_lab4;

  localparam int CLK_NS      = 8;
  localparam int SCLK_DIV    = 2;
  localparam int FRAME_CLKS  = 18 * 2 * SCLK_DIV;  // 18 sclk periods
  localparam int STEP_CLKS   = 8;                  // One encoder detent
  localparam int MAX_STEPS   = 20;
  localparam int NUM_ROWS    = 14;
  localparam int WATCHDOG_NS =
    (NUM_ROWS * (3 * FRAME_CLKS + MAX_STEPS * STEP_CLKS) + 4 * FRAME_CLKS) * CLK_NS;

  localparam logic [3:0] ADC_CMD_BITS = 4'b1101;  // Start, single ended, ch 0, MSB first
  localparam logic [3:0] DAC_CFG_BITS = 4'b0011;
  // Active low gfedcba for digits 0 to F
  localparam logic [6:0] SEG_TAB [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};

  typedef struct packed {
    logic [11:0] sample;
    logic        en;
    logic        mode;
    int          steps;   // Signed encoder detents
    logic [3:0]  gain;    // Gain after the steps
    logic [11:0] code;    // Expected DAC code
  } row_t;

  logic        clk = 1'b0;
  logic [2:0]  button;
  logic [9:0]  sw;
  logic        enc_a, enc_b;
  logic        adc_sdo;      // Model output towards the DUT
  logic [11:0] adc_word = '0;
  wire  [6:0]  hex0_d, hex1_d, hex2_d, hex3_d;
  wire         hex0_dp, hex1_dp, hex2_dp, hex3_dp;
  wire  [9:0]  ledg;
  wire  [1:0]  gpio0_clkout, gpio1_clkout;
  wire  [31:0] gpio0_d, gpio1_d;

  row_t rows [NUM_ROWS];
  int   row_cnt    = 0;
  int   model_gain = 4;      // Knob position seen by the table
  int   seed       = 37187;
  int   errors     = 0;
  int   checks     = 0;
  int   tests      = 0;

  // Serial bus observation
  logic        sclk_q = 1'b0;
  logic        dac_sclk_q = 1'b0;
  logic [4:0]  adc_cnt = '0;        // sclk rises since chip select fell
  logic [11:0] adc_shift = '0;
  logic [3:0]  cmd_shift = 4'b1101;
  logic [4:0]  dac_cnt = '0;
  logic [15:0] dac_shift = '0;
  logic [15:0] dac_last = '0;       // Last complete DAC word
  int          dac_words = 0;
  wire sclk_rise = (gpio0_d[11] === 1'b1) && (sclk_q === 1'b0);
  wire sclk_fall = (gpio0_d[11] === 1'b0) && (sclk_q === 1'b1);
  wire dac_sclk_rise = (gpio0_d[6] === 1'b1) && (dac_sclk_q === 1'b0);

  assign gpio0_d[12] = adc_sdo;
  assign gpio0_d[5]  = enc_a;
  assign gpio0_d[4]  = enc_b;

  always #(CLK_NS / 2) clk = ~clk;

  lab4 #(.SCLK_DIV(SCLK_DIV)) i_lab4 (
    .clock_50(clk), .clock_50_2(1'b0), .button(button), .sw(sw),
    .hex0_d(hex0_d), .hex0_dp(hex0_dp), .hex1_d(hex1_d), .hex1_dp(hex1_dp),
    .hex2_d(hex2_d), .hex2_dp(hex2_dp), .hex3_d(hex3_d), .hex3_dp(hex3_dp),
    .ledg(ledg), .gpio0_clkin(2'b00), .gpio0_clkout(gpio0_clkout), .gpio0_d(gpio0_d),
    .gpio1_clkin(2'b00), .gpio1_clkout(gpio1_clkout), .gpio1_d(gpio1_d));

  // ==================================================
  // Checks and reference model
  // ==================================================
  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // Detents all go one way, so clamping the sum equals stepwise saturation
  function automatic int clamp_gain(input int g);
    if (g < 0) return 0;
    if (g > 15) return 15;
    return g;
  endfunction

  function automatic logic [11:0] expected_code(input logic [11:0] s, input logic en,
                                                 input logic mode, input int g);
    int v;
    if (!en) return 12'd2048;   // Muted
    if (!mode) return s;        // Straight through
    v = int'(s) - 2048;
    v = (v * g) >>> 2;          // Floor of a quarter
    v = v + 2048;
    if (v < 0) v = 0;
    if (v > 4095) v = 4095;
    return 12'(v);
  endfunction

  task automatic add_row(input logic [11:0] s, input logic en, input logic mode,
                         input int steps);
    model_gain = clamp_gain(model_gain + steps);
    rows[row_cnt] = '{sample: s, en: en, mode: mode, steps: steps,
                      gain: 4'(model_gain), code: expected_code(s, en, mode, model_gain)};
    row_cnt++;
  endtask

  task automatic verify_display(input logic [11:0] code, input logic [3:0] gain,
                                input logic en, input logic mode, input logic rst);
    compare("hex0_d", 32'(hex0_d), 32'(SEG_TAB[code[3:0]]));
    compare("hex1_d", 32'(hex1_d), 32'(SEG_TAB[code[7:4]]));
    compare("hex2_d", 32'(hex2_d), 32'(SEG_TAB[code[11:8]]));
    compare("hex3_d", 32'(hex3_d), 32'(SEG_TAB[gain]));
    compare("ledg[2:0]", 32'(ledg[2:0]), 32'({en, mode, rst}));
  endtask

  // Outputs tied off by the board top
  task automatic verify_fixed_outputs();
    compare("hex0_dp", 32'(hex0_dp), 32'd1);  // Decimal points dark
    compare("hex1_dp", 32'(hex1_dp), 32'd1);
    compare("hex2_dp", 32'(hex2_dp), 32'd1);
    compare("hex3_dp", 32'(hex3_dp), 32'd1);
    compare("ledg[9:3]", 32'(ledg[9:3]), 32'd0);
    compare("gpio0_clkout", 32'(gpio0_clkout), 32'd0);
    compare("gpio1_clkout", 32'(gpio1_clkout), 32'd0);
  endtask

  // ==================================================
  // Bus models
  // ==================================================
  always @(posedge clk) begin
    sclk_q     <= gpio0_d[11];  // ADC side clock
    dac_sclk_q <= gpio0_d[6];
  end

  // ADC model checks the command on rises and drives data after falls
  always @(posedge clk) begin
    if (sclk_rise) begin
      if (gpio0_d[14] === 1'b1) begin
        adc_cnt   <= '0;          // Between frames
        adc_shift <= adc_word;
        cmd_shift <= ADC_CMD_BITS;
      end else begin
        if (adc_cnt < 5'd4) begin
          compare("gpio0_d[13]", 32'(gpio0_d[13]), 32'(cmd_shift[3]));
          cmd_shift <= {cmd_shift[2:0], 1'b0};
        end
        adc_cnt <= adc_cnt + 1'b1;
      end
    end else if (sclk_fall && gpio0_d[14] === 1'b0 && adc_cnt >= 5'd5 && adc_cnt <= 5'd16) begin
      adc_sdo   <= adc_shift[11];   // MSB first in periods 5 to 16
      adc_shift <= {adc_shift[10:0], 1'b0};
    end
  end

  // DAC capture of 16 bits on rises of its own sclk pin while selected
  always @(posedge clk) begin
    if (dac_sclk_rise) begin
      if (gpio0_d[8] === 1'b0) begin
        dac_shift <= {dac_shift[14:0], gpio0_d[7]};
        if (dac_cnt == 5'd15) begin
          dac_last  <= {dac_shift[14:0], gpio0_d[7]};
          dac_words <= dac_words + 1;
          dac_cnt   <= '0;
        end else begin
          dac_cnt <= dac_cnt + 1'b1;
        end
      end else begin
        dac_cnt <= '0;
      end
    end
  end

  // ==================================================
  // Stimulus
  // ==================================================
  task automatic wait_dac_word();
    int start;
    start = dac_words;
    while (dac_words == start) @(posedge clk);
  endtask

  task automatic turn_knob(input int steps);
    int n;
    n = (steps < 0) ? -steps : steps;
    repeat (n) begin
      @(posedge clk);
      enc_b <= (steps < 0);       // B high turns down
      repeat (2) @(posedge clk);
      enc_a <= 1'b1;
      repeat (3) @(posedge clk);
      enc_a <= 1'b0;
      repeat (2) @(posedge clk);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("TIMEOUT: run did not finish within %0d ns, DAC words seen %0d",
             WATCHDOG_NS, dac_words);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    int errs_before;
    button  = 3'b110;   // Button 0 pressed holds reset
    sw      = '0;
    enc_a   = 1'b0;
    enc_b   = 1'b0;
    adc_sdo = 1'b0;

    add_row(12'($random(seed)), 1'b1, 1'b0, 0);
    add_row(12'($random(seed)), 1'b1, 1'b0, 0);
    add_row(12'($random(seed)), 1'b1, 1'b0, 0);
    add_row(12'd3000, 1'b1, 1'b1, 0);      // Unity
    add_row(12'd3000, 1'b1, 1'b1, 4);
    add_row(12'd3000, 1'b1, 1'b1, 2);      // Top rail
    add_row(12'd100,  1'b1, 1'b1, 0);      // Bottom rail
    add_row(12'd2100, 1'b1, 1'b1, 20);     // Gain stops at 15
    add_row(12'($random(seed)), 1'b1, 1'b1, -20);
    add_row(12'd2047, 1'b1, 1'b1, -3);     // Gain stops at 0
    add_row(12'd2047, 1'b1, 1'b1, 5);      // Floor below midscale
    add_row(12'($random(seed)), 1'b0, 1'b1, 0);
    add_row(12'd4000, 1'b0, 1'b0, 0);
    add_row(12'($random(seed)), 1'b1, 1'b0, -1);

    repeat (4) @(posedge clk);
    compare("gpio0_d[14]", 32'(gpio0_d[14]), 32'd1);
    compare("gpio0_d[8]", 32'(gpio0_d[8]), 32'd1);
    compare("gpio0_d[11]", 32'(gpio0_d[11]), 32'd0);
    compare("gpio0_d[13]", 32'(gpio0_d[13]), 32'd0);
    compare("gpio0_d[7]", 32'(gpio0_d[7]), 32'd0);
    verify_display(12'd2048, 4'd4, 1'b0, 1'b0, 1'b1);
    verify_fixed_outputs();
    button <= 3'b111;

    errs_before = errors;
    wait_dac_word();
    compare("dac word", 32'(dac_last), 32'({DAC_CFG_BITS, 12'd2048}));
    tests++;
    $display("reset: first DAC word 0x%04h %s", dac_last,
             (errors == errs_before) ? "ok" : "mismatch");

    for (int i = 0; i < NUM_ROWS; i++) begin
      errs_before = errors;
      @(posedge clk);
      sw <= {8'b0, rows[i].en, rows[i].mode};
      turn_knob(rows[i].steps);
      wait_dac_word();            // Settings in place before the next sample
      adc_word <= rows[i].sample;
      wait_dac_word();            // Still carries the older sample
      wait_dac_word();
      compare("dac word", 32'(dac_last), 32'({DAC_CFG_BITS, rows[i].code}));
      repeat (2) @(posedge clk);
      verify_display(rows[i].code, rows[i].gain, rows[i].en, rows[i].mode, 1'b0);
      verify_fixed_outputs();
      tests++;
      $display("row %0d: sample %03h en %0b mode %0b steps %0d gain %0d code %03h %s",
               i, rows[i].sample, rows[i].en, rows[i].mode, rows[i].steps, rows[i].gain,
               rows[i].code, (errors == errs_before) ? "ok" : "mismatch");
    end

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
